/* src/mm_cfg_pkg.sv */
// Matrix-multiply engine control definitions
// Register map, CTRL opcodes, scheduler states and the
// configuration and status bundles shared by the control blocks

package mm_cfg_pkg;

  // ==============================
  // AXI4-Lite register map
  // ==============================
  localparam int unsigned AXI_ADDR_W = 4;
  localparam int unsigned AXI_DATA_W = 32;

  localparam logic [AXI_ADDR_W-1:0] REG_CTRL      = 4'h0;
  localparam logic [AXI_ADDR_W-1:0] REG_K_LEN     = 4'h4;
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 4'h8;
  localparam logic [AXI_ADDR_W-1:0] REG_JOB_COUNT = 4'hC;

  // Job length in input beats
  localparam int unsigned K_LEN_W = 16;

  // ==============================
  // Encodings
  // ==============================
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_START = 2'd1,
    OP_CLEAR = 2'd2
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2,
    ST_OUT   = 2'd3
  } sched_state_e;

  // Register file to scheduler and beat counter
  typedef struct packed {
    logic [K_LEN_W-1:0] k_len;
    logic               start;
    logic               clear;
  } cfg_t;

  // Scheduler back to register file
  typedef struct packed {
    logic busy;
    logic job_done;
  } status_t;

endpackage

/* src/mm_data_pkg.sv */
// Matrix-multiply engine datapath definitions
// Element and accumulator types, input beat layout, products
// and the result vector carried on the output stream

package mm_data_pkg;

  // ==============================
  // Array geometry
  // ==============================
  // Rows of X, one accumulator each
  localparam int unsigned ARR_WIDTH  = 4;
  // Elements per row, also the length of W
  localparam int unsigned ARR_HEIGHT = 4;

  localparam int unsigned ELEM_W = 8;
  localparam int unsigned ACC_W  = 32;

  // Multiply stage plus row-sum stage
  localparam int unsigned ENGINE_STAGES = 2;

  // ==============================
  // Types
  // ==============================
  typedef logic signed [ELEM_W-1:0]   elem_t;
  // Full-precision product of two elements
  typedef logic signed [2*ELEM_W-1:0] prod_t;
  // Wrapping accumulator
  typedef logic signed [ACC_W-1:0]    acc_t;

  // One input beat, X block in the upper bits and W vector below
  typedef struct packed {
    elem_t [ARR_WIDTH-1:0][ARR_HEIGHT-1:0] x;
    elem_t [ARR_HEIGHT-1:0]                w;
  } in_beat_t;

  // Products of one beat, indexed [row][element]
  typedef prod_t [ARR_WIDTH-1:0][ARR_HEIGHT-1:0] prod_blk_t;

  // Partial sums and final result, one entry per row
  typedef acc_t [ARR_WIDTH-1:0] z_vec_t;

endpackage

/* src/mm_regfile.sv */
// AXI4-Lite configuration slave for the matrix-multiply engine
// Holds K_LEN, the sticky done flag and the finished-job counter,
// and turns CTRL writes into one-cycle start and clear pulses

`timescale 1ns/100ps

module mm_regfile
  import mm_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write address and data
  input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  logic [AXI_DATA_W-1:0] s_axi_wdata_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  // Write response
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  // Read address and data
  input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output logic [AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  // Job control
  output cfg_t                  cfg_o,
  input  status_t               status_i
);

  logic                  wr_en;
  logic                  rd_en;
  logic                  bvalid_q;
  logic                  rvalid_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic [AXI_DATA_W-1:0] rd_word;
  logic [K_LEN_W-1:0]    k_len_q;
  logic                  start_q;
  logic                  clear_q;
  logic                  done_q;
  logic [AXI_DATA_W-1:0] job_count_q;
  opcode_e               wr_op;

  // ==============================
  // Handshakes
  // ==============================
  // Address and data taken together, one response outstanding
  assign wr_en = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid_q;
  assign rd_en = s_axi_arvalid_i && !rvalid_q;

  assign s_axi_awready_o = wr_en;
  assign s_axi_wready_o  = wr_en;
  assign s_axi_arready_o = rd_en;

  // Always OKAY
  assign s_axi_bresp_o  = 2'b00;
  assign s_axi_rresp_o  = 2'b00;
  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rdata_o  = rdata_q;

  assign wr_op = opcode_e'(s_axi_wdata_i[1:0]);

  // Write side, K_LEN and CTRL pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      k_len_q  <= '0;
      start_q  <= 1'b0;
      clear_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
      if (wr_en) begin
        bvalid_q <= 1'b1;
        case (s_axi_awaddr_i)
          REG_CTRL: begin
            // Start is dropped while a job runs
            start_q <= (wr_op == OP_START) && !status_i.busy;
            clear_q <= (wr_op == OP_CLEAR);
          end
          REG_K_LEN: k_len_q <= s_axi_wdata_i[K_LEN_W-1:0];
          default: ;
        endcase
      end else if (s_axi_bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Sticky done flag and finished-job count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q      <= 1'b0;
      job_count_q <= '0;
    end else if (status_i.job_done) begin
      done_q      <= 1'b1;
      job_count_q <= job_count_q + 1'b1;
    end else if (start_q || clear_q) begin
      done_q <= 1'b0;
    end
  end

  // ==============================
  // Read side
  // ==============================
  // CTRL, reserved bits and unmapped offsets read zero
  always_comb begin
    rd_word = '0;
    case (s_axi_araddr_i)
      REG_K_LEN:     rd_word[K_LEN_W-1:0] = k_len_q;
      REG_STATUS:    rd_word[1:0] = {done_q, status_i.busy};
      REG_JOB_COUNT: rd_word = job_count_q;
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (rd_en) begin
      rvalid_q <= 1'b1;
    end else if (s_axi_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // Read data held with rvalid
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  assign cfg_o = '{k_len: k_len_q, start: start_q, clear: clear_q};

endmodule

/* src/mm_scheduler.sv */
// Job scheduler for the matrix-multiply engine
// Opens the input stream for K_LEN beats, waits for the engine
// to drain, then presents the result until the sink takes it

`timescale 1ns/100ps

module mm_scheduler
  import mm_cfg_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  cfg_t    cfg_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  logic    last_beat_i,
  input  logic    all_retired_i,
  input  logic    out_ready_i,
  output logic    eng_valid_o,
  output logic    acc_clear_o,
  output logic    out_load_o,
  output logic    out_valid_o,
  output status_t status_o
);

  sched_state_e state_q;
  sched_state_e state_d;

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:  if (cfg_i.start) state_d = ST_RUN;
      // All K_LEN beats accepted
      ST_RUN:   if (last_beat_i) state_d = ST_DRAIN;
      // Last partial vector already in the accumulators
      ST_DRAIN: if (all_retired_i) state_d = ST_OUT;
      ST_OUT:   if (out_ready_i) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
    // Clear aborts from anywhere
    if (cfg_i.clear) begin
      state_d = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==============================
  // Stream and datapath control
  // ==============================
  assign in_ready_o  = (state_q == ST_RUN) && !last_beat_i;
  // One engine issue per accepted beat
  assign eng_valid_o = in_valid_i && in_ready_o;

  // Fresh sums for a new job, and dropped sums on abort
  assign acc_clear_o = cfg_i.start || cfg_i.clear;

  // Snapshot the accumulators on the way into ST_OUT
  assign out_load_o  = (state_q == ST_DRAIN) && all_retired_i;
  assign out_valid_o = (state_q == ST_OUT);

  assign status_o.busy     = (state_q != ST_IDLE);
  // Output handshake finishes the job unless aborted in the same cycle
  assign status_o.job_done = (state_q == ST_OUT) && out_ready_i && !cfg_i.clear;

endmodule

/* src/mm_beat_counter.sv */
// Beat bookkeeping for the running job
// Tracks accepted input beats and retired engine results against K_LEN

`timescale 1ns/100ps

module mm_beat_counter
  import mm_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  cfg_t cfg_i,
  input  logic beat_accept_i,
  input  logic result_valid_i,
  output logic last_beat_o,
  output logic all_retired_o
);

  // Job length captured at start, later K_LEN writes wait for the next job
  logic [K_LEN_W-1:0] k_len_q;
  logic [K_LEN_W-1:0] accepted_q;
  logic [K_LEN_W-1:0] retired_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      k_len_q    <= '0;
      accepted_q <= '0;
      retired_q  <= '0;
    end else if (cfg_i.start || cfg_i.clear) begin
      accepted_q <= '0;
      retired_q  <= '0;
      if (cfg_i.start) begin
        k_len_q <= cfg_i.k_len;
      end
    end else begin
      if (beat_accept_i) begin
        accepted_q <= accepted_q + 1'b1;
      end
      if (result_valid_i) begin
        retired_q <= retired_q + 1'b1;
      end
    end
  end

  assign last_beat_o   = (accepted_q == k_len_q);
  assign all_retired_o = (retired_q == k_len_q);

endmodule

/* src/mm_engine.sv */
// Two-stage integer dot-product engine
// Stage 1 registers the signed 8x8 products, stage 2 the row sums,
// giving one partial-sum vector per beat two cycles after issue

`timescale 1ns/100ps

module mm_engine
  import mm_data_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     valid_i,
  input  in_beat_t beat_i,
  output logic     valid_o,
  output z_vec_t   part_o
);

  // One valid bit per stage
  logic [ENGINE_STAGES-1:0] vld_q;
  prod_blk_t                prod_q;
  z_vec_t                   row_sum;
  z_vec_t                   sum_q;

  // Flush drops whatever is in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (flush_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[ENGINE_STAGES-2:0], valid_i};
    end
  end

  // ==============================
  // Stage 1, multipliers
  // ==============================
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      for (int r = 0; r < ARR_WIDTH; r++) begin
        for (int c = 0; c < ARR_HEIGHT; c++) begin
          // Sign-extend both operands before the multiply
          prod_q[r][c] <= prod_t'(beat_i.x[r][c]) * prod_t'(beat_i.w[c]);
        end
      end
    end
  end

  // ==============================
  // Stage 2, row reduction
  // ==============================
  always_comb begin
    for (int r = 0; r < ARR_WIDTH; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < ARR_HEIGHT; c++) begin
        row_sum[r] = row_sum[r] + acc_t'(prod_q[r][c]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (vld_q[0]) begin
      sum_q <= row_sum;
    end
  end

  assign valid_o = vld_q[ENGINE_STAGES-1];
  assign part_o  = sum_q;

endmodule

/* src/mm_z_buffer.sv */
// Result accumulators for the matrix-multiply engine
// Adds each partial vector into four wrapping sums and
// holds a snapshot of them for the output stream

`timescale 1ns/100ps

module mm_z_buffer
  import mm_data_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   acc_clear_i,
  input  logic   add_i,
  input  z_vec_t part_i,
  input  logic   out_load_i,
  output z_vec_t z_o
);

  z_vec_t acc_q;
  z_vec_t out_q;

  // Clear wins over a partial arriving in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (acc_clear_i) begin
      acc_q <= '0;
    end else if (add_i) begin
      for (int r = 0; r < ARR_WIDTH; r++) begin
        acc_q[r] <= acc_q[r] + part_i[r];
      end
    end
  end

  // Stable through ST_OUT, accumulators can be cleared behind it
  always_ff @(posedge clk_i) begin
    if (out_load_i) begin
      out_q <= acc_q;
    end
  end

  assign z_o = out_q;

endmodule

/* src/mm_top.sv */
// Integer matrix-multiply engine, top level
// AXI4-Lite configuration, valid/ready input beats of X and W,
// one result beat of four row sums per job

`timescale 1ns/100ps

module mm_top
  import mm_cfg_pkg::*;
  import mm_data_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  logic [AXI_DATA_W-1:0] s_axi_wdata_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output logic [AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  // Input beat stream
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  in_beat_t              in_data_i,
  // Result stream
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output z_vec_t                out_data_o
);

  cfg_t    cfg;
  status_t status;
  logic    eng_valid;
  logic    acc_clear;
  logic    out_load;
  logic    last_beat;
  logic    all_retired;
  logic    part_valid;
  z_vec_t  part;

  // ==============================
  // Control
  // ==============================
  mm_regfile u_regfile (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .cfg_o           (cfg),
    .status_i        (status)
  );

  mm_scheduler u_scheduler (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .last_beat_i   (last_beat),
    .all_retired_i (all_retired),
    .out_ready_i   (out_ready_i),
    .eng_valid_o   (eng_valid),
    .acc_clear_o   (acc_clear),
    .out_load_o    (out_load),
    .out_valid_o   (out_valid_o),
    .status_o      (status)
  );

  // Accepted beats and retired results share the job length
  mm_beat_counter u_beat_counter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_i          (cfg),
    .beat_accept_i  (eng_valid),
    .result_valid_i (part_valid),
    .last_beat_o    (last_beat),
    .all_retired_o  (all_retired)
  );

  // ==============================
  // Datapath
  // ==============================
  mm_engine u_engine (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (cfg.clear),
    .valid_i (eng_valid),
    .beat_i  (in_data_i),
    .valid_o (part_valid),
    .part_o  (part)
  );

  mm_z_buffer u_z_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_clear_i (acc_clear),
    .add_i       (part_valid),
    .part_i      (part),
    .out_load_i  (out_load),
    .z_o         (out_data_o)
  );

endmodule

/* sim/mm_top_properties.sv */
// Handshake properties for the matrix-multiply engine
// Bound into the top level, checks the stream and AXI4-Lite hold rules

`timescale 1ns/100ps

module mm_top_properties
  import mm_data_pkg::*;
(
  input logic   clk_i,
  input logic   rst_ni,
  input logic   start_i,
  input logic   clear_i,
  input logic   in_ready_i,
  input logic   out_valid_i,
  input logic   out_ready_i,
  input z_vec_t out_data_i,
  input logic   bvalid_i,
  input logic   bready_i,
  input logic   rvalid_i,
  input logic   rready_i
);

  // Job window from the start pulse up to the result handshake or a clear
  logic job_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_q <= 1'b0;
    end else if (clear_i || (out_valid_i && out_ready_i)) begin
      job_q <= 1'b0;
    end else if (start_i) begin
      job_q <= 1'b1;
    end
  end

  // Result beat held with its data until the sink takes it
  out_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else $error("result beat dropped or changed before its handshake");

  // Input stream closed while no job runs
  in_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !job_q |-> !in_ready_i)
    else $error("input ready raised outside a job");

  // Write response held until bready
  b_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("write response dropped before bready");

  // Read response held until rready
  r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("read response dropped before rready");

endmodule

bind mm_top mm_top_properties u_properties (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .start_i     (cfg.start),
  .clear_i     (cfg.clear),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_data_i  (out_data_o),
  .bvalid_i    (s_axi_bvalid_o),
  .bready_i    (s_axi_bready_i),
  .rvalid_i    (s_axi_rvalid_o),
  .rready_i    (s_axi_rready_i)
);

/* sim/tb_mm_top.sv */
// Testbench for the matrix-multiply engine
// Runs the jobs of the data file through the AXI4-Lite and stream ports,
// checks results, STATUS and JOB_COUNT, and aborts one job with clear

`timescale 1ns/100ps

module tb_mm_top
  import mm_cfg_pkg::*;
  import mm_data_pkg::*;
();

  localparam int unsigned WORD_W    = $bits(in_beat_t);
  localparam int unsigned MEM_DEPTH = 64;

  logic                  clk_i;
  logic                  rst_ni;
  // AXI4-Lite master side
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  // Streams
  logic                  in_valid;
  logic                  in_ready;
  in_beat_t              in_data;
  logic                  out_valid;
  logic                  out_ready;
  z_vec_t                out_data;

  // Job records as laid out in the data file
  logic [WORD_W-1:0] testdata [0:MEM_DEPTH-1];
  integer            seed;
  int unsigned       limit_cycles = 0;
  int unsigned       errors;
  int unsigned       jobs_done;

  mm_top u_mm_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .in_valid_i      (in_valid),
    .in_ready_o      (in_ready),
    .in_data_i       (in_data),
    .out_valid_o     (out_valid),
    .out_ready_i     (out_ready),
    .out_data_o      (out_data)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Run limit scales with the beats in the data file
  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  // ==============================
  // Checks and bus tasks
  // ==============================
  task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Done: errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
                           input logic [AXI_DATA_W-1:0] data);
    @(negedge clk_i);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b1;
    // bvalid rises on the edge that takes address and data
    @(negedge clk_i);
    while (!bvalid) @(negedge clk_i);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_value("s_axi_bresp_o", bresp, 2'b00);
    // Response taken on the next edge with bready already high
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
                          output logic [AXI_DATA_W-1:0] data);
    @(negedge clk_i);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    // rvalid and rdata follow the edge that takes the address
    @(negedge clk_i);
    while (!rvalid) @(negedge clk_i);
    arvalid = 1'b0;
    data    = rdata;
    check_value("s_axi_rresp_o", rresp, 2'b00);
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic read_expect(input logic [AXI_ADDR_W-1:0] addr, input string name,
                             input logic [AXI_DATA_W-1:0] exp);
    logic [AXI_DATA_W-1:0] data;
    axi_read(addr, data);
    check_value(name, data, exp);
  endtask

  // ==============================
  // Stream tasks
  // ==============================
  // Beats k of the record at base, with random idle cycles between them
  task automatic send_beats(input int unsigned base, input int unsigned k);
    int gap;
    @(negedge clk_i);
    for (int unsigned i = 0; i < k; i++) begin
      gap = $random(seed) & 3;
      if (gap > 1) begin
        in_valid = 1'b0;
        repeat (gap - 1) @(negedge clk_i);
      end
      in_valid = 1'b1;
      in_data  = testdata[base + 1 + i];
      // in_ready comes from registered state and holds until the next edge
      while (!in_ready) @(negedge clk_i);
      // Beat taken on the edge just passed
      @(negedge clk_i);
    end
    in_valid = 1'b0;
  endtask

  // Sink with random stalls on out_ready
  task automatic receive_result(output z_vec_t z);
    logic got;
    got = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      out_ready = ($random(seed) & 3) != 0;
      // Handshake on the coming edge
      if (out_valid && out_ready) begin
        z   = out_data;
        got = 1'b1;
      end
    end
    @(negedge clk_i);
    out_ready = 1'b0;
  endtask

  // ==============================
  // Job sequences
  // ==============================
  task automatic run_job(input int unsigned base);
    int unsigned k;
    z_vec_t      z;
    k = testdata[base][K_LEN_W-1:0];
    axi_write(REG_K_LEN, k);
    axi_write(REG_CTRL, 32'(OP_START));
    // Busy with done cleared by the start
    read_expect(REG_STATUS, "STATUS", 32'h1);
    fork
      send_beats(base, k);
      receive_result(z);
    join
    jobs_done++;
    check_value("out_data_o", z, testdata[base + k + 1]);
    // Done and idle once the result is taken
    read_expect(REG_STATUS, "STATUS", 32'h2);
    read_expect(REG_JOB_COUNT, "JOB_COUNT", jobs_done);
  endtask

  // Start a 4-beat job, feed half of it, then clear
  task automatic abort_job(input int unsigned base);
    logic [AXI_DATA_W-1:0] count;
    axi_read(REG_JOB_COUNT, count);
    axi_write(REG_K_LEN, 32'd4);
    axi_write(REG_CTRL, 32'(OP_START));
    send_beats(base, 2);
    axi_write(REG_CTRL, 32'(OP_CLEAR));
    // Beats offered after the abort must find the stream closed
    in_valid = 1'b1;
    in_data  = testdata[base + 1];
    repeat (8) begin
      check_value("in_ready_o", in_ready, 1'b0);
      check_value("out_valid_o", out_valid, 1'b0);
      @(negedge clk_i);
    end
    in_valid = 1'b0;
    read_expect(REG_STATUS, "STATUS", 32'h0);
    read_expect(REG_JOB_COUNT, "JOB_COUNT", count);
  endtask

  initial begin : stimulus
    int unsigned ptr;
    int unsigned k;
    int unsigned job;
    int unsigned total_beats;
    rst_ni    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    seed      = 32'h791a_7a6a;
    errors    = 0;
    jobs_done = 0;

    // Walk the job records once to size the watchdog
    $readmemh("sim/mm_testdata.txt", testdata);
    ptr         = 0;
    job         = 0;
    total_beats = 0;
    while (ptr < MEM_DEPTH && testdata[ptr][K_LEN_W-1:0] != 0) begin
      k            = testdata[ptr][K_LEN_W-1:0];
      total_beats += k;
      job++;
      ptr += k + 2;
    end
    if (job == 0) begin
      $display("No jobs found in sim/mm_testdata.txt");
      $display("Done: errors found");
      $fatal(1, "empty data file");
    end
    limit_cycles = total_beats * 10 + job * 200 + 1000;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Everything quiet after reset
    check_value("in_ready_o", in_ready, 1'b0);
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("s_axi_bvalid_o", bvalid, 1'b0);
    check_value("s_axi_rvalid_o", rvalid, 1'b0);
    check_value("s_axi_awready_o", awready, 1'b0);
    check_value("s_axi_wready_o", wready, 1'b0);
    check_value("s_axi_arready_o", arready, 1'b0);
    read_expect(REG_STATUS, "STATUS", 32'h0);

    // K_LEN keeps 16 bits
    axi_write(REG_K_LEN, 32'hABCD_1234);
    read_expect(REG_K_LEN, "K_LEN", 32'h0000_1234);
    // CTRL and unmapped offsets read zero
    read_expect(REG_CTRL, "CTRL", 32'h0);
    read_expect(4'h2, "unmapped 0x2", 32'h0);
    read_expect(REG_JOB_COUNT, "JOB_COUNT", 32'h0);

    ptr = 0;
    job = 0;
    while (ptr < MEM_DEPTH && testdata[ptr][K_LEN_W-1:0] != 0) begin
      k = testdata[ptr][K_LEN_W-1:0];
      // Abort just ahead of the third job, which then must be clean
      if (job == 2) begin
        abort_job(ptr);
      end
      run_job(ptr);
      job++;
      ptr += k + 2;
    end

    @(negedge clk_i);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim/mm_testdata.txt */
// Per job: K_LEN, then K_LEN beats {x row3..row0, w}, then result {z3..z0}
// Hex, highest index first within each row and vector; K_LEN 0 ends the list
// Job 0: one beat, W = 4 3 2 1
1
02020202ffffffff000000000403020104030201
00000014fffffff6000000000000001e
// Job 1: extreme and negative values over three beats
3
00000000010101017f7f7f7f8080808080808080
800000000000006407fc03050a0a0a0afe02ff01
01020304ffffffff000000007f7f7f7f01010101
0000010afffffe60ffff01ec000101fc
// Job 2: runs after an aborted job
2
0404040403030303020202020101010101010101
0404040403030303020202020101010102020202
0000003000000024000000180000000c
// End of list
0

/* tb.f */
src/mm_cfg_pkg.sv
src/mm_data_pkg.sv
src/mm_regfile.sv
src/mm_scheduler.sv
src/mm_beat_counter.sv
src/mm_engine.sv
src/mm_z_buffer.sv
src/mm_top.sv
sim/mm_top_properties.sv
sim/tb_mm_top.sv

/* Makefile */
# Verilator simulation of the matrix-multiply engine

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mm_top -f tb.f -o Vtb_mm_top
	@out=$$(./obj_dir/Vtb_mm_top); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
